//--- design/rv32_csr_pkg.sv
package rv32_csr_pkg;

    // machine information and trap setup
    localparam logic [11:0] csr_mstatus  = 12'h300;
    localparam logic [11:0] csr_misa     = 12'h301;
    localparam logic [11:0] csr_mtvec    = 12'h305;

    localparam logic [11:0] csr_mhpmevent_first = 12'h323;
    localparam logic [11:0] csr_mhpmevent_last  = 12'h33F;

    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;
    localparam logic [11:0] csr_mcause   = 12'h342;

    // pmp is not implemented so both blocks read as zero
    localparam logic [11:0] csr_pmpcfg_first  = 12'h3A0;
    localparam logic [11:0] csr_pmpcfg_last   = 12'h3A3;
    localparam logic [11:0] csr_pmpaddr_first = 12'h3B0;
    localparam logic [11:0] csr_pmpaddr_last  = 12'h3BF;

    // machine counters
    localparam logic [11:0] csr_mcycle   = 12'hB00;
    localparam logic [11:0] csr_minstret = 12'hB02;

    localparam logic [11:0] csr_mhpmcounter_first = 12'hB03;
    localparam logic [11:0] csr_mhpmcounter_last  = 12'hB1F;

    localparam logic [11:0] csr_mcycleh   = 12'hB80;
    localparam logic [11:0] csr_minstreth = 12'hB82;

    localparam logic [11:0] csr_mhpmcounterh_first = 12'hB83;
    localparam logic [11:0] csr_mhpmcounterh_last  = 12'hB9F;

    // user counter shadows
    localparam logic [11:0] csr_cycle    = 12'hC00;
    localparam logic [11:0] csr_time     = 12'hC01;
    localparam logic [11:0] csr_instret  = 12'hC02;
    localparam logic [11:0] csr_cycleh   = 12'hC80;
    localparam logic [11:0] csr_timeh    = 12'hC81;
    localparam logic [11:0] csr_instreth = 12'hC82;

    // id registers
    localparam logic [11:0] csr_mvendorid = 12'hF11;
    localparam logic [11:0] csr_marchid   = 12'hF12;
    localparam logic [11:0] csr_mimpid    = 12'hF13;
    localparam logic [11:0] csr_mhartid   = 12'hF14;

    // mxl = 1 for 32 bit with only the I extension
    localparam logic [31:0] misa_value = 32'h4000_0100;

    localparam logic [6:0] opcode_system = 7'b1110011;

    typedef enum logic [1:0] {
        op_rw = 2'b00,
        op_rs = 2'b01,
        op_rc = 2'b10
    } csr_op_e;

    typedef enum logic {
        src_imm = 1'b0,
        src_reg = 1'b1
    } csr_src_e;

    typedef struct packed {
        logic        valid;
        logic        is_csr;
        logic [11:0] addr;
        csr_op_e     op;
        logic [31:0] operand;
        logic [4:0]  rd;
        logic        do_read;
        logic        do_write;
    } csr_req_t;

    typedef struct packed {
        logic        valid;
        logic        rd_write;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        illegal;
    } csr_res_t;

endpackage

//--- design/rv32_csr_decode.sv
`timescale 1ns/10ps

module rv32_csr_decode
    import rv32_csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_value,
    output csr_req_t    req
);
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1_field;
    logic [4:0]  rd_field;
    logic [11:0] csr_field;
    logic        is_csr;
    csr_op_e     op;
    csr_src_e    src;
    logic [31:0] operand;
    csr_req_t    req_next;

    assign opcode    = instr[6:0];
    assign rd_field  = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1_field = instr[19:15];
    assign csr_field = instr[31:20];

    // funct3 0 and 4 under SYSTEM are not csr accesses
    assign is_csr = (opcode == opcode_system) && (funct3[1:0] != 2'b00);

    always_comb begin
        case (funct3[1:0])
            2'b01:   op = op_rw;
            2'b10:   op = op_rs;
            2'b11:   op = op_rc;
            default: op = op_rw;
        endcase
    end

    assign src     = funct3[2] ? src_imm : src_reg;
    assign operand = (src == src_reg) ? rs1_value : {27'b0, rs1_field};

    always_comb begin
        req_next.valid   = instr_valid;
        req_next.is_csr  = is_csr;
        req_next.addr    = csr_field;
        req_next.op      = op;
        req_next.operand = operand;
        req_next.rd      = rd_field;
        // csrrw with rd = x0 must not cause read side effects
        req_next.do_read  = is_csr && !(op == op_rw && rd_field == 5'd0);
        // set/clear with rs1 field = 0 is a pure read
        req_next.do_write = is_csr && (op == op_rw || rs1_field != 5'd0);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req <= '0;
        end else if (!stall) begin
            req <= req_next;
        end
    end

    a_hold_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable(req)
    );

endmodule

//--- design/rv32_csrs.sv
`timescale 1ns/10ps

module rv32_csrs
    import rv32_csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  csr_req_t req,
    input  logic     instr_retired,
    output csr_res_t res
);
    logic        mstatus_mpie;
    logic        mstatus_mie;
    logic [31:2] mtvec_base;
    logic        mtvec_mode;
    logic [31:0] mscratch;
    logic [31:2] mepc;
    logic        mcause_int;
    logic [3:0]  mcause_code;
    logic [63:0] cycle;
    logic [63:0] instret;

    logic [31:0] old_value;
    logic [31:0] new_value;
    logic        known;
    logic        zero_range;
    logic        csr_we;
    csr_res_t    res_next;

    function automatic logic in_range(
        input logic [11:0] a,
        input logic [11:0] lo,
        input logic [11:0] hi
    );
        return (a >= lo) && (a <= hi);
    endfunction

    // unimplemented counter, event and pmp blocks read as zero
    assign zero_range = in_range(req.addr, csr_mhpmevent_first, csr_mhpmevent_last)
                     || in_range(req.addr, csr_pmpcfg_first, csr_pmpcfg_last)
                     || in_range(req.addr, csr_pmpaddr_first, csr_pmpaddr_last)
                     || in_range(req.addr, csr_mhpmcounter_first, csr_mhpmcounter_last)
                     || in_range(req.addr, csr_mhpmcounterh_first, csr_mhpmcounterh_last);

    always_comb begin
        known     = 1'b1;
        old_value = 32'b0;
        if (!zero_range) begin
            case (req.addr)
                csr_mstatus:
                    old_value = {19'b0, 2'b11, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
                csr_misa:      old_value = misa_value;
                csr_mtvec:     old_value = {mtvec_base, 1'b0, mtvec_mode};
                csr_mscratch:  old_value = mscratch;
                csr_mepc:      old_value = {mepc, 2'b00};
                csr_mcause:    old_value = {mcause_int, 27'b0, mcause_code};
                csr_mcycle:    old_value = cycle[31:0];
                csr_minstret:  old_value = instret[31:0];
                csr_mcycleh:   old_value = cycle[63:32];
                csr_minstreth: old_value = instret[63:32];
                // time is tied to the cycle counter
                csr_cycle:     old_value = cycle[31:0];
                csr_time:      old_value = cycle[31:0];
                csr_instret:   old_value = instret[31:0];
                csr_cycleh:    old_value = cycle[63:32];
                csr_timeh:     old_value = cycle[63:32];
                csr_instreth:  old_value = instret[63:32];
                csr_mvendorid: old_value = 32'b0;
                csr_marchid:   old_value = 32'b0;
                csr_mimpid:    old_value = 32'b0;
                csr_mhartid:   old_value = 32'b0;
                default:       known = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (req.op)
            op_rw:   new_value = req.operand;
            op_rs:   new_value = old_value | req.operand;
            op_rc:   new_value = old_value & ~req.operand;
            default: new_value = req.operand;
        endcase
    end

    assign csr_we = req.valid && req.do_write && known && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mpie <= 1'b0;
            mstatus_mie  <= 1'b0;
            mtvec_base   <= '0;
            mtvec_mode   <= 1'b0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_code  <= '0;
        end else if (csr_we) begin
            case (req.addr)
                csr_mstatus: begin
                    mstatus_mpie <= new_value[7];
                    mstatus_mie  <= new_value[3];
                end
                csr_mtvec: begin
                    mtvec_base <= new_value[31:2];
                    mtvec_mode <= new_value[0];
                end
                csr_mscratch: mscratch <= new_value;
                csr_mepc:     mepc <= new_value[31:2];
                csr_mcause: begin
                    mcause_int  <= new_value[31];
                    mcause_code <= new_value[3:0];
                end
                default: ;
            endcase
        end
    end

    // cycle keeps running through stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle   <= '0;
            instret <= '0;
        end else begin
            cycle   <= cycle + 64'd1;
            instret <= instret + {63'b0, instr_retired};
        end
    end

    always_comb begin
        res_next.valid    = req.valid;
        res_next.rd_write = req.valid && req.is_csr && known && req.do_read;
        res_next.rd       = req.rd;
        res_next.data     = old_value;
        res_next.illegal  = req.valid && req.is_csr && !known;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else if (!stall) begin
            res <= res_next;
        end
    end

    a_no_write_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable({mstatus_mpie, mstatus_mie, mtvec_base, mtvec_mode,
                           mscratch, mepc, mcause_int, mcause_code})
    );

    a_illegal_no_rd: assert property (
        @(posedge clk) disable iff (!rst_n)
        res.valid |-> !(res.illegal && res.rd_write)
    );

endmodule

//--- design/rv32_csr_writeback.sv
`timescale 1ns/10ps

module rv32_csr_writeback
    import rv32_csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  csr_res_t    res,
    output logic        rd_write,
    output logic        illegal,
    output logic        instr_retired,
    output logic [4:0]  rd_addr,
    output logic [31:0] rd_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_write      <= 1'b0;
            illegal       <= 1'b0;
            instr_retired <= 1'b0;
        end else if (stall) begin
            // bubble while execute holds its result until the stall clears
            rd_write      <= 1'b0;
            illegal       <= 1'b0;
            instr_retired <= 1'b0;
        end else begin
            rd_write      <= res.valid && res.rd_write && (res.rd != 5'd0);
            illegal       <= res.valid && res.illegal;
            instr_retired <= res.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rd_addr <= res.rd;
            rd_data <= res.data;
        end
    end

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_write |-> (rd_addr != 5'd0)
    );

endmodule

//--- design/rv32_csr_unit.sv
`timescale 1ns/10ps

module rv32_csr_unit
    import rv32_csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_value,
    output logic        rd_write,
    output logic [4:0]  rd_addr,
    output logic [31:0] rd_data,
    output logic        illegal
);
    csr_req_t req;
    csr_res_t res;
    logic     instr_retired;

    rv32_csr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .req         (req)
    );

    rv32_csrs u_csrs (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .req           (req),
        .instr_retired (instr_retired),
        .res           (res)
    );

    // retire pulse loops back into instret
    rv32_csr_writeback u_writeback (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .res           (res),
        .rd_write      (rd_write),
        .illegal       (illegal),
        .instr_retired (instr_retired),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held low for the first 10 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- test/rv32_csr_unit_tb.sv
`timescale 1ns/10ps

module rv32_csr_unit_tb;
    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_value;
    logic        rd_write;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        illegal;

    // result kinds are 0 none, 1 data, 2 illegal, 3 instret count,
    // 4 previous plus delta and 5 any data
    int          exp_kind[$];
    logic [31:0] exp_data[$];
    logic [4:0]  exp_rd[$];

    int          seed;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          issued;
    logic [31:0] last_data;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv32_csr_unit DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_value   (rs1_value),
        .rd_write    (rd_write),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .illegal     (illegal)
    );

    always @(posedge clk) begin : monitor
        int          kind;
        logic [31:0] want_data;
        logic [4:0]  want_rd;
        logic        want_ill;
        if (rst_n && (rd_write || illegal)) begin
            assert (exp_kind.size() != 0) else begin
                $display("ERROR: result at %0t arrived with no instruction outstanding", $time);
                errors++;
            end
            if (exp_kind.size() != 0) begin
                kind      = exp_kind.pop_front();
                want_data = exp_data.pop_front();
                want_rd   = exp_rd.pop_front();
                want_ill  = (kind == 2);
                if (kind == 4) begin
                    want_data = last_data + want_data;
                end else if (kind == 5) begin
                    want_data = rd_data;
                end
                assert (illegal == want_ill && rd_write == !want_ill
                        && (want_ill || (rd_addr == want_rd && rd_data == want_data))) else begin
                    $display("MISMATCH at %0t: rd_write %0b rd x%0d data %08h illegal %0b, %s",
                             $time, rd_write, rd_addr, rd_data, illegal,
                             $sformatf("expected x%0d data %08h illegal %0b",
                                       want_rd, want_data, want_ill));
                    errors++;
                end
            end
            if (rd_write) begin
                last_data = rd_data;
            end
        end
    end

    function automatic logic pick_stall(input bit stall_en);
        // roughly one cycle in four stalls inside a stall section
        if (!stall_en) begin
            return 1'b0;
        end
        return ($random(seed) & 3) == 0;
    endfunction

    task automatic drive_instruction(input bit stall_en, input logic [31:0] word,
                                     input logic [31:0] rs1, input int kind,
                                     input logic [31:0] data);
        int   tries;
        logic st;
        tries = 0;
        st    = 1'b1;
        // hold the word until a cycle without stall takes it
        while (st && tries < 50) begin
            @(posedge clk);
            st = pick_stall(stall_en);
            stall       <= st;
            instr_valid <= 1'b1;
            instr       <= word;
            rs1_value   <= rs1;
            tries++;
        end
        if (st) begin
            $display("ERROR: instruction %08h was never accepted within 50 cycles", word);
            errors++;
        end else begin
            if (kind != 0) begin
                exp_kind.push_back(kind);
                exp_data.push_back(kind == 3 ? issued : data);
                exp_rd.push_back(word[11:7]);
            end
            issued++;
        end
    endtask

    task automatic idle_cycles(input bit stall_en, input int gap);
        repeat (gap) begin
            @(posedge clk);
            stall       <= pick_stall(stall_en);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic finish_test(input int test_id, input int errors_before);
        int count;
        @(posedge clk);
        stall       <= 1'b0;
        instr_valid <= 1'b0;
        count = 0;
        while (exp_kind.size() != 0 && count < 50) begin
            @(posedge clk);
            count++;
        end
        if (exp_kind.size() != 0) begin
            $display("ERROR: test %0d timed out with %0d results still missing",
                     test_id, exp_kind.size());
            errors++;
            exp_kind.delete();
            exp_data.delete();
            exp_rd.delete();
        end
        // a few quiet cycles so a duplicated result would still show up
        repeat (4) @(posedge clk);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %0d passed", test_id);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", test_id, errors - errors_before);
        end
    endtask

    initial begin
        int          fd;
        int          count;
        int          cur_test;
        int          errors_before;
        int          t;
        int          st;
        int          gap;
        int          kind;
        logic [31:0] word;
        logic [31:0] rs1;
        logic [31:0] data;
        string       line;
        stall         = 1'b0;
        instr_valid   = 1'b0;
        instr         = 32'b0;
        rs1_value     = 32'b0;
        seed          = 32'h399e;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        issued        = 0;
        last_data     = 32'b0;
        cur_test      = -1;
        errors_before = 0;

        count = 0;
        while (!rst_n && count < 50) begin
            @(posedge clk);
            count++;
        end
        if (!rst_n) begin
            $display("ERROR: reset was never released");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            fd = $fopen("test/csr_stimulus.txt", "r");
            if (fd == 0) begin
                $display("ERROR: could not open the stimulus file");
                $display("*** TEST FAILED ***");
                $finish;
            end else begin
                while (!$feof(fd)) begin
                    line = "";
                    void'($fgets(line, fd));
                    if ($sscanf(line, "%d %d %h %h %d %d %h",
                                t, st, word, rs1, gap, kind, data) == 7) begin
                        if (t != cur_test) begin
                            if (cur_test >= 0) begin
                                finish_test(cur_test, errors_before);
                            end
                            cur_test      = t;
                            errors_before = errors;
                        end
                        drive_instruction(st != 0, word, rs1, kind, data);
                        idle_cycles(st != 0, gap);
                    end
                end
                $fclose(fd);
                if (cur_test >= 0) begin
                    finish_test(cur_test, errors_before);
                end
                $display("tests passed %0d, tests failed %0d, errors %0d",
                         tests_passed, tests_failed, errors);
                if (errors == 0 && tests_failed == 0 && tests_passed > 0) begin
                    $display("*** TEST PASSED ***");
                end else begin
                    $display("*** TEST FAILED ***");
                end
                $finish;
            end
        end
    end

endmodule

//--- test/csr_stimulus.txt
# test stall instr rs1 gap kind data (hex for instr, rs1, data)
# kind 0 none, 1 rd data, 2 illegal, 3 instret count, 4 previous plus data, 5 any data
1 0 340092F3 12345678 0 1 00000000
1 0 340022F3 00000000 1 1 12345678
1 0 3400A2F3 0000F00F 0 1 12345678
1 0 340022F3 00000000 0 1 1234F67F
1 0 3400B2F3 1200000F 1 1 1234F67F
1 0 340022F3 00000000 0 1 0034F670
2 0 30009073 FFFFFFFF 0 0 00000000
2 0 300022F3 00000000 0 1 00001888
2 0 30509073 FFFFFFFF 0 0 00000000
2 0 305022F3 00000000 0 1 FFFFFFFD
2 0 34109073 FFFFFFFF 0 0 00000000
2 0 341022F3 00000000 0 1 FFFFFFFC
2 0 34209073 FFFFFFFF 0 0 00000000
2 0 342022F3 00000000 0 1 8000000F
2 0 300472F3 DEADBEEF 0 1 00001888
2 0 300062F3 FFFFFFFF 0 1 00001880
2 0 342032F3 FFFFFFFF 0 1 8000000F
2 0 342022F3 00000000 0 1 8000000F
2 0 340AD2F3 DEADBEEF 0 1 0034F670
2 0 340022F3 00000000 0 1 00000015
3 0 301022F3 00000000 1 1 40000100
3 0 323022F3 00000000 1 1 00000000
3 0 3A0022F3 00000000 1 1 00000000
3 0 B03022F3 00000000 1 1 00000000
3 0 F11022F3 00000000 0 1 00000000
3 0 F14022F3 00000000 0 1 00000000
3 0 7C0022F3 00000000 1 2 00000000
3 0 00100093 00000000 1 0 00000000
4 0 B00022F3 00000000 0 5 00000000
4 0 B00022F3 00000000 0 4 00000001
4 0 C00022F3 00000000 0 4 00000001
4 0 C01022F3 00000000 3 4 00000001
4 0 00100093 00000000 3 0 00000000
4 0 B02022F3 00000000 3 3 00000000
4 0 B80022F3 00000000 3 1 00000000
4 0 C02022F3 00000000 3 3 00000000
5 1 340092F3 11111111 0 1 00000015
5 1 340092F3 22222222 0 1 11111111
5 1 3400A2F3 00000044 0 1 22222222
5 1 3400B2F3 00000202 1 1 22222266
5 1 340092F3 A5A5A5A5 0 1 22222064
5 1 3401D2F3 00000000 0 1 A5A5A5A5
5 1 340022F3 00000000 0 1 00000003

//--- verilog.f
design/rv32_csr_pkg.sv
design/rv32_csr_decode.sv
design/rv32_csrs.sv
design/rv32_csr_writeback.sv
design/rv32_csr_unit.sv
test/tb_clock_gen.sv
test/rv32_csr_unit_tb.sv

//--- Makefile
# Verilator build for the CSR unit testbench
# override on the command line, e.g. make run SIM=verilator TOP=rv32_csr_unit_tb

SIM      ?= verilator
TOP      ?= rv32_csr_unit_tb
FLAGS    ?= --binary --timing --assert -Wno-fatal
FILELIST ?= verilog.f
OBJ_DIR  ?= obj_dir
PASS_MSG ?= *** TEST PASSED ***

EXE := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(EXE))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
